// File: build.f
source/memctl_pkg.sv
source/snes_sync.sv
source/slot_sequencer.sv
source/addr_map.sv
source/mcu_apb_port.sv
source/sram_ctrl.sv
source/memctl_top.sv
tests/memctl_asserts.sv
tests/memctl_tb.sv

// File: Bender.yml
package:
  name: memctl

sources:
  - source/memctl_pkg.sv
  - source/snes_sync.sv
  - source/slot_sequencer.sv
  - source/addr_map.sv
  - source/mcu_apb_port.sv
  - source/sram_ctrl.sv
  - source/memctl_top.sv
  - target: test
    files:
      - tests/memctl_asserts.sv
      - tests/memctl_tb.sv

// File: tests/memctl_tb.sv
`timescale 1ns/10ps

module memctl_tb import memctl_pkg::*;;

   // Run length budget
   localparam int NUM_TESTS      = 40;
   localparam int CYC_PER_TEST   = 24;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * CYC_PER_TEST * 2;

   logic CLK2, rst_n;
   logic [ADDR_W-1:0] snes_addr, paddr;
   logic [DATA_W-1:0] snes_wdata, snes_rdata, pwdata, prdata;
   logic snes_rd_n, snes_wr_n, snes_cs_n, snes_cpu_clk, snes_data_oe;
   logic [SRAM_ADDR_W-1:0] sram_addr;
   logic [SRAM_DATA_W-1:0] sram_wdata, sram_rdata;
   logic sram_data_oe, sram_we_n, sram_oe_n, sram_bhe_n, sram_ble_n;
   logic psel, penable, pwrite, pready;

   integer seed = 61;
   int     err_cnt = 0;
   int     cycle_cnt = 0;
   int     mem_ver = 0;
   logic [SRAM_DATA_W-1:0] sram_mem [int];
   logic [DATA_W-1:0]      shadow [int];
   // Pending checks for the compare process
   string             name_q[$];
   bit                kind_q[$];
   logic [DATA_W-1:0] act_q[$];
   logic [DATA_W-1:0] exp_q[$];

   memctl_top UUT (.*);

   initial begin
      CLK2 = 1'b0;
      forever #5 CLK2 = ~CLK2;
   end

   ////////////////////////////////////////////////////////////
   // SRAM model and shadow memory
   ////////////////////////////////////////////////////////////
   // Power-up pattern over every address bit
   function automatic logic [DATA_W-1:0] fill_byte(input logic [ADDR_W-1:0] a);
      fill_byte = a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
   endfunction

   function automatic logic [SRAM_DATA_W-1:0] model_word(input logic [SRAM_ADDR_W-1:0] w);
      if (sram_mem.exists(int'(w))) begin
         model_word = sram_mem[int'(w)];
      end else begin
         model_word = {fill_byte({w, 1'b1}), fill_byte({w, 1'b0})};
      end
   endfunction

   function automatic logic [DATA_W-1:0] model_byte(input logic [ADDR_W-1:0] a);
      logic [SRAM_DATA_W-1:0] w;
      w = model_word(a[ADDR_W-1:1]);
      model_byte = a[0] ? w[15:8] : w[7:0];
   endfunction

   function automatic logic [DATA_W-1:0] shadow_byte(input logic [ADDR_W-1:0] a);
      shadow_byte = shadow.exists(int'(a)) ? shadow[int'(a)] : fill_byte(a);
   endfunction

   // Asynchronous read while OE is low
   always @(sram_addr, sram_oe_n, mem_ver) begin
      sram_rdata = !sram_oe_n ? model_word(sram_addr) : '0;
   end

   // Write in mid clock when the registered strobes are settled
   always @(negedge CLK2) begin : sram_write
      logic [SRAM_DATA_W-1:0] w;
      if (!sram_oe_n && sram_data_oe) begin
         end_with_failure("SRAM data bus driven by both sides at once");
      end
      if (!sram_we_n) begin
         if (!sram_data_oe) begin
            end_with_failure("SRAM write strobe without write data on the bus");
         end
         w = model_word(sram_addr);
         if (!sram_bhe_n) begin
            w[15:8] = sram_wdata[15:8];
         end
         if (!sram_ble_n) begin
            w[7:0] = sram_wdata[7:0];
         end
         sram_mem[int'(sram_addr)] = w;
         mem_ver++;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference address map
   ////////////////////////////////////////////////////////////
   // Returns {rom hit, save RAM hit, SRAM byte address}
   function automatic logic [ADDR_W+1:0] ref_map(input logic [ADDR_W-1:0] a);
      logic              rom, sav;
      logic [ADDR_W-1:0] off, ba;
      rom = a[15];
      sav = (a[23:20] == SAVERAM_BANK_HI) && (a[15] == 1'b0);
      if (sav) begin
         off = (ADDR_W'(a[19:16]) << 15) | ADDR_W'(a[14:0]);
         ba  = SAVERAM_BASE + (off & SAVERAM_MASK);
      end else begin
         // 32 KB per bank from the upper halves
         ba = ((ADDR_W'(a[22:16]) << 15) | ADDR_W'(a[14:0])) & ROM_MASK;
      end
      ref_map = {rom, sav, ba};
   endfunction

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////
   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [DATA_W-1:0] act,
                             input logic [DATA_W-1:0] exp);
      if (act !== exp) begin
         err_cnt++;
         end_with_failure($sformatf("FAILED t=%0t %s got %h expected %h",
                                    $time, name, act, exp));
      end
   endtask

   task automatic check_acc(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         err_cnt++;
         end_with_failure($sformatf("FAILED t=%0t %s got %b expected %b",
                                    $time, name, act, exp));
      end
   endtask

   task automatic post(input string name, input bit is_byte, input logic [DATA_W-1:0] act,
                       input logic [DATA_W-1:0] exp);
      name_q.push_back(name);
      kind_q.push_back(is_byte);
      act_q.push_back(act);
      exp_q.push_back(exp);
   endtask

   // Compare process
   initial begin
      forever begin
         wait (name_q.size() != 0);
         if (kind_q[0]) begin
            check_byte(name_q[0], act_q[0], exp_q[0]);
         end else begin
            check_acc(name_q[0], act_q[0][0], exp_q[0][0]);
         end
         void'(name_q.pop_front());
         void'(kind_q.pop_front());
         void'(act_q.pop_front());
         void'(exp_q.pop_front());
      end
   end

   // Watchdog
   always @(posedge CLK2) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         end_with_failure("Timeout: the run did not finish within the cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////
   // n edges then 1 ns of hold
   task automatic tick(input int n);
      repeat (n) @(posedge CLK2);
      #1;
   endtask

   // One 24 clock SNES cycle of 6 low, 6 high and 12 low
   // Address and strobes stay put until the slots have run
   task automatic snes_cycle(input snes_acc_t kind, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] wd, input bit sel);
      logic [ADDR_W+1:0] m;
      m = ref_map(a);
      snes_addr    = a;
      snes_wdata   = wd;
      snes_cs_n    = !sel;
      snes_rd_n    = (kind != ACC_READ);
      snes_wr_n    = (kind != ACC_WRITE);
      snes_cpu_clk = 1'b0;
      tick(6);
      snes_cpu_clk = 1'b1;
      tick(6);
      snes_cpu_clk = 1'b0;
      tick(12);
      if (kind != ACC_NONE) begin
         post("is_rom", 1'b0, UUT.is_rom, m[ADDR_W+1]);
         post("is_saveram", 1'b0, UUT.is_saveram, m[ADDR_W]);
         post("snes_data_oe", 1'b0, snes_data_oe,
              sel && (kind == ACC_READ) && (m[ADDR_W+1] || m[ADDR_W]));
      end
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
   endtask

   task automatic apb_xfer(input bit wr, input logic [ADDR_W-1:0] a,
                           input logic [DATA_W-1:0] wd, output logic [DATA_W-1:0] rd);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = a;
      pwdata  = wd;
      tick(1);
      penable = 1'b1;
      // pready alone marks completion
      do @(negedge CLK2); while (!pready);
      rd = prdata;
      tick(1);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // APB access with SNES cycles running for the MCU slots
   task automatic apb_served(input bit wr, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] wd, output logic [DATA_W-1:0] rd);
      bit                done;
      logic [DATA_W-1:0] r;
      done = 1'b0;
      fork
         begin
            apb_xfer(wr, a, wd, r);
            done = 1'b1;
         end
         while (!done) snes_cycle(ACC_NONE, '0, '0, 1'b0);
      join
      rd = r;
   endtask

   function automatic logic [ADDR_W-1:0] rand_rom();
      rand_rom = $random(seed);
      rand_rom[15] = 1'b1;
   endfunction

   function automatic logic [ADDR_W-1:0] rand_sav();
      rand_sav = $random(seed);
      rand_sav[23:20] = SAVERAM_BANK_HI;
      rand_sav[15] = 1'b0;
   endfunction

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin : main
      logic [ADDR_W-1:0] a, ba;
      logic [DATA_W-1:0] d, rd;
      bit                sel, apb_done;
      rst_n = 1'b0;
      snes_addr = '0;
      snes_wdata = '0;
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      snes_cpu_clk = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      tick(4);
      rst_n = 1'b1;
      tick(3);

      // Idle state after reset
      post("sram_we_n", 1'b0, sram_we_n, 1'b1);
      post("sram_oe_n", 1'b0, sram_oe_n, 1'b1);
      post("sram_bhe_n", 1'b0, sram_bhe_n, 1'b1);
      post("sram_ble_n", 1'b0, sram_ble_n, 1'b1);
      post("sram_data_oe", 1'b0, sram_data_oe, 1'b0);
      post("snes_data_oe", 1'b0, snes_data_oe, 1'b0);
      post("pready", 1'b0, pready, 1'b0);

      // ROM reads with chip select mostly on
      repeat (8) begin
         a   = rand_rom();
         ba  = ref_map(a);
         sel = ($random(seed) % 4) != 0;
         snes_cycle(ACC_READ, a, '0, sel);
         post("snes_rdata", 1'b1, snes_rdata, shadow_byte(ba));
      end

      // Save RAM writes land but ROM writes do not
      repeat (6) begin
         a  = rand_sav();
         ba = ref_map(a);
         d  = $random(seed);
         snes_cycle(ACC_WRITE, a, d, 1'b1);
         shadow[int'(ba)] = d;
         post("sram save RAM byte", 1'b1, model_byte(ba), d);
      end
      repeat (2) begin
         a  = rand_rom();
         ba = ref_map(a);
         snes_cycle(ACC_WRITE, a, $random(seed), 1'b1);
         post("sram ROM byte", 1'b1, model_byte(ba), shadow_byte(ba));
      end

      // MCU write then SNES read
      repeat (3) begin
         a  = rand_rom();
         ba = ref_map(a);
         d  = $random(seed);
         apb_served(1'b1, ba, d, rd);
         shadow[int'(ba)] = d;
         snes_cycle(ACC_READ, a, '0, 1'b1);
         post("snes_rdata", 1'b1, snes_rdata, d);
      end

      // SNES write then MCU read
      repeat (3) begin
         a  = rand_sav();
         ba = ref_map(a);
         d  = $random(seed);
         snes_cycle(ACC_WRITE, a, d, 1'b1);
         shadow[int'(ba)] = d;
         apb_served(1'b0, ba, '0, rd);
         post("prdata", 1'b1, rd, d);
      end

      // APB held off while the CPU clock is idle
      ba = ref_map(rand_rom());
      apb_done = 1'b0;
      fork
         begin
            apb_xfer(1'b0, ba, '0, rd);
            apb_done = 1'b1;
         end
         begin
            tick(40);
            post("APB done while idle", 1'b0, apb_done, 1'b0);
            while (!apb_done) snes_cycle(ACC_NONE, '0, '0, 1'b0);
         end
      join
      post("prdata", 1'b1, rd, shadow_byte(ba));

      wait (name_q.size() == 0);
      #1;
      if (err_cnt != 0) begin
         end_with_failure("Mismatches were found");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

// File: tests/memctl_asserts.sv
`timescale 1ns/10ps

module memctl_asserts (
   input logic CLK2,
   input logic rst_n,
   input logic we_n,
   input logic oe_n,
   input logic bhe_n,
   input logic ble_n,
   input logic psel,
   input logic penable,
   input logic pready
);

   // SRAM bus contention
   a_we_oe : assert property (@(posedge CLK2) disable iff (!rst_n) !(!we_n && !oe_n))
      else $error("SRAM WE and OE low together");

   // Completion only inside an APB access phase
   a_pready : assert property (@(posedge CLK2) disable iff (!rst_n)
                               pready |-> (psel && penable))
      else $error("pready outside an access phase");

   // One lane at a time
   a_lanes : assert property (@(posedge CLK2) disable iff (!rst_n) !(!bhe_n && !ble_n))
      else $error("Both SRAM byte lanes enabled");

endmodule

bind sram_ctrl memctl_asserts u_sram_chk (
   .CLK2(CLK2), .rst_n(rst_n), .we_n(sram_we_n), .oe_n(sram_oe_n),
   .bhe_n(sram_bhe_n), .ble_n(sram_ble_n),
   .psel(1'b0), .penable(1'b0), .pready(1'b0)
);

bind mcu_apb_port memctl_asserts u_apb_chk (
   .CLK2(CLK2), .rst_n(rst_n), .we_n(1'b1), .oe_n(1'b1),
   .bhe_n(1'b1), .ble_n(1'b1),
   .psel(psel), .penable(penable), .pready(pready)
);

// File: source/memctl_top.sv
`timescale 1ns/10ps

module memctl_top import memctl_pkg::*; (
   input  logic                   CLK2,
   input  logic                   rst_n,
   // SNES cartridge bus
   input  logic [ADDR_W-1:0]      snes_addr,
   input  logic [DATA_W-1:0]      snes_wdata,
   input  logic                   snes_rd_n, snes_wr_n, snes_cs_n, snes_cpu_clk,
   output logic [DATA_W-1:0]      snes_rdata,
   output logic                   snes_data_oe,
   // SRAM
   output logic [SRAM_ADDR_W-1:0] sram_addr,
   output logic [SRAM_DATA_W-1:0] sram_wdata,
   output logic                   sram_data_oe,
   input  logic [SRAM_DATA_W-1:0] sram_rdata,
   output logic                   sram_we_n, sram_oe_n, sram_bhe_n, sram_ble_n,
   // MCU APB
   input  logic                   psel, penable, pwrite,
   input  logic [ADDR_W-1:0]      paddr,
   input  logic [DATA_W-1:0]      pwdata,
   output logic [DATA_W-1:0]      prdata,
   output logic                   pready
);

   logic              cycle_start, rd_n_s, wr_n_s;
   slot_t             slot;
   snes_acc_t         snes_acc;
   logic              mcu_req, mcu_we, mcu_done;
   logic [ADDR_W-1:0] mcu_addr, sram_byte_addr;
   logic [DATA_W-1:0] mcu_wdata, mcu_rdata;
   logic              is_rom, is_saveram;

   // CPU clock edge to cycle start pulse
   snes_sync u_sync (
      .CLK2(CLK2), .rst_n(rst_n), .snes_cpu_clk(snes_cpu_clk),
      .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
      .cycle_start(cycle_start), .rd_n_s(rd_n_s), .wr_n_s(wr_n_s)
   );

   slot_sequencer u_seq (
      .CLK2(CLK2), .rst_n(rst_n), .cycle_start(cycle_start),
      .rd_n_s(rd_n_s), .wr_n_s(wr_n_s), .slot(slot), .snes_acc(snes_acc)
   );

   addr_map u_map (
      .slot(slot), .snes_addr(snes_addr), .mcu_addr(mcu_addr),
      .sram_byte_addr(sram_byte_addr), .is_rom(is_rom), .is_saveram(is_saveram)
   );

   mcu_apb_port u_apb (
      .CLK2(CLK2), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .mcu_req(mcu_req), .mcu_we(mcu_we), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
      .mcu_done(mcu_done), .mcu_rdata(mcu_rdata)
   );

   // Shared SRAM, SNES slots first then MCU slots
   sram_ctrl u_sram (
      .CLK2(CLK2), .rst_n(rst_n), .slot(slot), .snes_acc(snes_acc),
      .is_rom(is_rom), .is_saveram(is_saveram), .sram_byte_addr(sram_byte_addr),
      .snes_wdata(snes_wdata), .snes_cs_n(snes_cs_n),
      .snes_rdata(snes_rdata), .snes_data_oe(snes_data_oe),
      .mcu_req(mcu_req), .mcu_we(mcu_we), .mcu_wdata(mcu_wdata),
      .mcu_rdata(mcu_rdata), .mcu_done(mcu_done),
      .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_data_oe(sram_data_oe),
      .sram_rdata(sram_rdata), .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n),
      .sram_bhe_n(sram_bhe_n), .sram_ble_n(sram_ble_n)
   );

endmodule

// File: source/sram_ctrl.sv
`timescale 1ns/10ps

module sram_ctrl import memctl_pkg::*; (
   input  logic                   CLK2,
   input  logic                   rst_n,
   input  slot_t                  slot,
   input  snes_acc_t              snes_acc,
   input  logic                   is_rom,
   input  logic                   is_saveram,
   input  logic [ADDR_W-1:0]      sram_byte_addr,
   // SNES data
   input  logic [DATA_W-1:0]      snes_wdata,
   input  logic                   snes_cs_n,
   output logic [DATA_W-1:0]      snes_rdata,
   output logic                   snes_data_oe,
   // MCU request
   input  logic                   mcu_req,
   input  logic                   mcu_we,
   input  logic [DATA_W-1:0]      mcu_wdata,
   output logic [DATA_W-1:0]      mcu_rdata,
   output logic                   mcu_done,
   // SRAM pins
   output logic [SRAM_ADDR_W-1:0] sram_addr,
   output logic [SRAM_DATA_W-1:0] sram_wdata,
   output logic                   sram_data_oe,
   input  logic [SRAM_DATA_W-1:0] sram_rdata,
   output logic                   sram_we_n,
   output logic                   sram_oe_n,
   output logic                   sram_bhe_n,
   output logic                   sram_ble_n
);

   logic             snes_phase, mcu_phase;
   logic             snes_rd_en, snes_wr_en;
   logic             mcu_rd_en, mcu_wr_en;
   logic             we_now, oe_now;
   logic             lane_q;
   logic [DATA_W-1:0] lane_byte;

   assign snes_phase = slot inside {[S0:S5]};
   assign mcu_phase  = slot inside {[S6:S12]};

   // Only ROM or save RAM hits touch the SRAM
   assign snes_rd_en = snes_phase && (snes_acc == ACC_READ) && (is_rom || is_saveram);
   // ROM is never written from the SNES side
   assign snes_wr_en = snes_phase && (snes_acc == ACC_WRITE) && is_saveram;
   assign mcu_rd_en  = mcu_phase && mcu_req && !mcu_we;
   assign mcu_wr_en  = mcu_phase && mcu_req && mcu_we;

   // Write strobe is a single slot wide
   assign we_now = (snes_wr_en && slot == SNES_WR_SLOT) || (mcu_wr_en && slot == MCU_ACC_SLOT);
   assign oe_now = snes_rd_en || mcu_rd_en;

   // Byte from the lane currently on the SRAM
   assign lane_byte = lane_q ? sram_rdata[SRAM_DATA_W-1:DATA_W] : sram_rdata[DATA_W-1:0];

   // Cartridge drives the SNES bus on selected read hits
   assign snes_data_oe = !snes_cs_n && (snes_acc == ACC_READ) && (is_rom || is_saveram);

   ////////////////////////////////////////////////////////////
   // Strobes and byte enables
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         sram_we_n    <= 1'b1;
         sram_oe_n    <= 1'b1;
         sram_bhe_n   <= 1'b1;
         sram_ble_n   <= 1'b1;
         sram_data_oe <= 1'b0;
         mcu_done     <= 1'b0;
      end else begin
         sram_we_n  <= !we_now;
         sram_oe_n  <= !oe_now;
         // A0 picks the lane
         sram_bhe_n <= !((we_now || oe_now) && sram_byte_addr[0]);
         sram_ble_n <= !((we_now || oe_now) && !sram_byte_addr[0]);
         // Drive write data for the whole phase of a write
         sram_data_oe <= snes_wr_en || mcu_wr_en;
         // A read is served only once OE was on in the slot before
         mcu_done     <= mcu_phase && mcu_req && (slot == MCU_ACC_SLOT) &&
                         (mcu_we || !sram_oe_n);
      end
   end

   ////////////////////////////////////////////////////////////
   // Address and data path
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      sram_addr <= sram_byte_addr[ADDR_W-1:1];
      lane_q    <= sram_byte_addr[0];
      // Same byte on both halves
      sram_wdata <= snes_phase ? {2{snes_wdata}} : {2{mcu_wdata}};
      // Captured on the edge into the latch slot
      if (snes_rd_en && (slot + 1) == SNES_RD_LATCH_SLOT) begin
         snes_rdata <= lane_byte;
      end
      if (mcu_rd_en && slot == MCU_ACC_SLOT) begin
         mcu_rdata <= lane_byte;
      end
   end

endmodule

// File: source/mcu_apb_port.sv
`timescale 1ns/10ps

module mcu_apb_port import memctl_pkg::*; (
   input  logic              CLK2,
   input  logic              rst_n,
   // APB slave
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   // Request towards the SRAM controller
   output logic              mcu_req,
   output logic              mcu_we,
   output logic [ADDR_W-1:0] mcu_addr,
   output logic [DATA_W-1:0] mcu_wdata,
   input  logic              mcu_done,
   input  logic [DATA_W-1:0] mcu_rdata
);

   logic accept;

   // Take a new access in the APB setup cycle
   // Only one request outstanding
   assign accept = psel && !penable && !mcu_req;

   ////////////////////////////////////////////////////////////
   // Request and handshake control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         mcu_req <= 1'b0;
         pready  <= 1'b0;
      end else begin
         // Completes one clock after the MCU slot served us
         pready <= mcu_done;
         if (mcu_done) begin
            mcu_req <= 1'b0;
         end else if (accept) begin
            // Held until an MCU phase serves it
            mcu_req <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Request payload and read data
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (accept) begin
         mcu_we    <= pwrite;
         mcu_addr  <= paddr;
         mcu_wdata <= pwdata;
      end
      // Valid together with pready
      if (mcu_done) begin
         prdata <= mcu_rdata;
      end
   end

endmodule

// File: source/addr_map.sv
`timescale 1ns/10ps

module addr_map import memctl_pkg::*; (
   input  slot_t             slot,
   input  logic [ADDR_W-1:0] snes_addr,
   input  logic [ADDR_W-1:0] mcu_addr,
   output logic [ADDR_W-1:0] sram_byte_addr,
   output logic              is_rom,
   output logic              is_saveram
);

   logic              snes_phase;
   logic [ADDR_W-1:0] rom_addr;
   logic [ADDR_W-1:0] sav_offset;
   logic [ADDR_W-1:0] sav_addr;

   // SNES owns the SRAM address in S0-S5 only
   assign snes_phase = slot inside {[S0:S5]};

   ////////////////////////////////////////////////////////////
   // Hit decode
   ////////////////////////////////////////////////////////////
   // Upper half of every bank is ROM
   assign is_rom = snes_addr[15];
   // Lower half of banks $70-$7F is save RAM
   assign is_saveram = (snes_addr[ADDR_W-1 -: 4] == SAVERAM_BANK_HI) && !snes_addr[15];

   ////////////////////////////////////////////////////////////
   // SRAM byte address
   ////////////////////////////////////////////////////////////
   // Bank low 7 bits + A14..A0, 32 KB per bank
   assign rom_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]} & ROM_MASK;

   // Bank nibble + A14..A0 as the save RAM offset
   assign sav_offset = {5'b0_0000, snes_addr[19:16], snes_addr[14:0]};
   assign sav_addr   = SAVERAM_BASE + (sav_offset & SAVERAM_MASK);

   always_comb begin
      if (!snes_phase) begin
         // MCU addresses the SRAM directly
         sram_byte_addr = mcu_addr;
      end else if (is_saveram) begin
         sram_byte_addr = sav_addr;
      end else begin
         // ROM form also for misses, nothing is strobed then
         sram_byte_addr = rom_addr;
      end
   end

endmodule

// File: source/slot_sequencer.sv
`timescale 1ns/10ps

module slot_sequencer import memctl_pkg::*; (
   input  logic      CLK2,
   input  logic      rst_n,
   input  logic      cycle_start,
   input  logic      rd_n_s,
   input  logic      wr_n_s,
   output slot_t     slot,
   output snes_acc_t snes_acc
);

   slot_t     slot_nxt;
   snes_acc_t acc_nxt;

   ////////////////////////////////////////////////////////////
   // Next slot
   ////////////////////////////////////////////////////////////
   always_comb begin
      if (cycle_start) begin
         // Restart from any slot, even mid cycle
         slot_nxt = S0;
      end else begin
         case (slot)
            // Last MCU slot, park until the next cycle
            S12:     slot_nxt = IDLE;
            IDLE:    slot_nxt = IDLE;
            // Slots are encoded in order
            default: slot_nxt = slot_t'(slot + 1);
         endcase
      end
   end

   // Access kind from the synchronized strobes
   // Read wins if both are low
   always_comb begin
      if (!rd_n_s) begin
         acc_nxt = ACC_READ;
      end else if (!wr_n_s) begin
         acc_nxt = ACC_WRITE;
      end else begin
         acc_nxt = ACC_NONE;
      end
   end

   ////////////////////////////////////////////////////////////
   // State registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         slot     <= IDLE;
         snes_acc <= ACC_NONE;
      end else begin
         slot <= slot_nxt;
         // Held for the whole cycle so strobes stay stable
         if (cycle_start) begin
            snes_acc <= acc_nxt;
         end
      end
   end

endmodule

// File: source/snes_sync.sv
`timescale 1ns/10ps

module snes_sync import memctl_pkg::*; (
   input  logic CLK2,
   input  logic rst_n,
   input  logic snes_cpu_clk,
   input  logic snes_rd_n,
   input  logic snes_wr_n,
   output logic cycle_start,
   output logic rd_n_s,
   output logic wr_n_s
);

   // Two flop synchronizers
   logic [1:0] clk_sync;
   logic [1:0] rd_sync;
   logic [1:0] wr_sync;
   // Shift history of the synchronized CPU clock
   logic [SYNC_DEPTH-1:0] clk_hist;

   always_ff @(posedge CLK2) begin
      if (!rst_n) begin
         clk_sync <= '0;
         // Strobes idle high
         rd_sync  <= '1;
         wr_sync  <= '1;
         clk_hist <= '0;
      end else begin
         clk_sync <= {clk_sync[0], snes_cpu_clk};
         rd_sync  <= {rd_sync[0], snes_rd_n};
         wr_sync  <= {wr_sync[0], snes_wr_n};
         clk_hist <= {clk_hist[SYNC_DEPTH-2:0], clk_sync[1]};
      end
   end

   // Rising CPU clock after a long low stretch
   // Single clock pulse since the history moves on next edge
   assign cycle_start = (clk_hist == CYCLE_START_PAT);

   assign rd_n_s = rd_sync[1];
   assign wr_n_s = wr_sync[1];

endmodule

// File: source/memctl_pkg.sv
package memctl_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////////////////////////
   // SNES and MCU byte address
   localparam int ADDR_W      = 24;
   // SRAM word address, one bit less than the byte address
   localparam int SRAM_ADDR_W = 23;
   localparam int DATA_W      = 8;
   localparam int SRAM_DATA_W = 16;

   // CPU clock history depth for cycle start detection
   localparam int SYNC_DEPTH = 6;
   // Five low samples then one high, newest sample in bit 0
   localparam logic [SYNC_DEPTH-1:0] CYCLE_START_PAT = {{(SYNC_DEPTH-1){1'b0}}, 1'b1};

   ////////////////////////////////////////////////////////////
   // LoROM style address map
   ////////////////////////////////////////////////////////////
   // 4 MB of ROM space
   localparam logic [ADDR_W-1:0] ROM_MASK        = 24'h3F_FFFF;
   // Save RAM lives in the top part of the SRAM
   localparam logic [ADDR_W-1:0] SAVERAM_BASE    = 24'hE0_0000;
   // 8 KB save RAM window
   localparam logic [ADDR_W-1:0] SAVERAM_MASK    = 24'h00_1FFF;
   // Banks $70-$7F below $8000
   localparam logic [3:0]        SAVERAM_BANK_HI = 4'h7;

   // Slots of one SNES cycle
   // S0-S5 SNES phase, S6-S12 MCU phase
   typedef enum logic [3:0] {
      S0, S1, S2, S3, S4, S5, S6, S7, S8, S9, S10, S11, S12, IDLE
   } slot_t;

   // Kind of SNES access, latched at cycle start
   typedef enum logic [1:0] {
      ACC_NONE, ACC_READ, ACC_WRITE
   } snes_acc_t;

   // Write strobe slot for save RAM writes
   localparam slot_t SNES_WR_SLOT       = S2;
   // snes_rdata valid from this slot on
   localparam slot_t SNES_RD_LATCH_SLOT = S4;
   // MCU read capture / write strobe / done pulse
   localparam slot_t MCU_ACC_SLOT       = S9;

endpackage
